/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

    // ########################################################################
    // Pixel and coordinate types
    // ########################################################################

    typedef logic [15:0] rgb565_t;              // R[15:11] G[10:5] B[4:0].
    typedef logic [7:0]  chan8_t;               // One HDMI colour channel.
    typedef logic [10:0] coord_t;               // Pixel or line index.

    // ########################################################################
    // Aiming box geometry
    // ########################################################################

    localparam coord_t  BOX_HALF_W = 11'd16;    // Half width in pixels.
    localparam coord_t  BOX_HALF_H = 11'd12;    // Half height in lines.
    localparam coord_t  BOX_LINE   = 11'd2;     // Outline thickness.

    // Pure red, full scale in the 5-bit field.
    localparam rgb565_t BOX_COLOR  = 16'hF800;

endpackage : video_pkg

`default_nettype wire

/* hdl/cam_pkg.sv */
`default_nettype none

package cam_pkg;

    // ########################################################################
    // Camera side types
    // ########################################################################

    typedef logic [7:0] cam_byte_t;             // One byte per cycle from the sensor.

    typedef enum logic {
        CAM_1 = 1'b0,
        CAM_2 = 1'b1
    } cam_sel_t;

    // ########################################################################
    // Display control FSM
    // ########################################################################

    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,                   // Display off.
        ST_WAIT_FRAME = 2'd1,                   // Waiting for a frame start.
        ST_RUN        = 2'd2                    // Streaming to HDMI.
    } ctrl_state_t;

endpackage : cam_pkg

`default_nettype wire

/* hdl/pixel_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pixel_bus_if;
    import video_pkg::*;

    logic    valid;                             // Single-cycle pixel strobe.
    rgb565_t data;
    logic    sof;                               // First pixel of a frame.
    logic    sol;                               // First pixel of a line.

    modport src (
        output valid,
        output data,
        output sof,
        output sol
    );

    modport dst (
        input  valid,
        input  data,
        input  sof,
        input  sol
    );

    // Control only needs frame starts.
    modport mon (
        input  valid,
        input  sof
    );

endinterface : pixel_bus_if

`default_nettype wire

/* hdl/cam_byte_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_byte_packer (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     vsync,
    input  wire                     href,
    input  wire cam_pkg::cam_byte_t data,
    pixel_bus_if.src                pix
);
    import cam_pkg::*;

    logic      vsync_q;
    logic      href_q;
    logic      vsync_rise;
    logic      href_rise;
    logic      phase_q;                         // High while the low byte is due.
    logic      sof_arm_q;
    logic      sol_arm_q;
    logic      emit;
    cam_byte_t hi_byte_q;

    assign vsync_rise = vsync & ~vsync_q;
    assign href_rise  = href & ~href_q;
    assign emit       = href & phase_q;

    // ########################################################################
    // Edge detect, byte phase and flag arming
    // ########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vsync_q   <= 1'b0;
            href_q    <= 1'b0;
            phase_q   <= 1'b0;
            sof_arm_q <= 1'b0;
            sol_arm_q <= 1'b0;
            pix.valid <= 1'b0;
        end else begin
            vsync_q   <= vsync;
            href_q    <= href;
            pix.valid <= emit;

            // Leftover odd byte is lost when href drops.
            if (!href || href_rise) begin
                phase_q <= href;
            end else begin
                phase_q <= ~phase_q;
            end

            if (vsync_rise) begin
                sof_arm_q <= 1'b1;
            end else if (emit) begin
                sof_arm_q <= 1'b0;
            end

            if (href_rise) begin
                sol_arm_q <= 1'b1;
            end else if (emit) begin
                sol_arm_q <= 1'b0;
            end
        end
    end

    // ########################################################################
    // Pixel assembly
    // ########################################################################

    always_ff @(posedge clk) begin
        if (href && !phase_q) begin
            hi_byte_q <= data;                  // R[4:0] G[5:3].
        end
        if (emit) begin
            pix.data <= {hi_byte_q, data};      // Low byte is G[2:0] B[4:0].
            pix.sof  <= sof_arm_q;
            pix.sol  <= sol_arm_q;
        end
    end

endmodule : cam_byte_packer

`default_nettype wire

/* hdl/aim_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module aim_ctrl (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    enable,
    input  wire cam_pkg::cam_sel_t cam_sel,
    pixel_bus_if.mon               cam1,
    pixel_bus_if.mon               cam2,
    output cam_pkg::cam_sel_t      active_cam,
    output logic                   disp_en,
    output logic                   cam_inited
);
    import cam_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    cam_sel_t    active_q;
    logic        sof1;
    logic        sof2;
    logic        sel_sof;
    logic        seen1_q;
    logic        seen2_q;

    assign sof1    = cam1.valid & cam1.sof;
    assign sof2    = cam2.valid & cam2.sof;
    assign sel_sof = (cam_sel == CAM_1) ? sof1 : sof2;

    // ########################################################################
    // State machine
    // ########################################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:       state_d = ST_WAIT_FRAME;
            ST_WAIT_FRAME: if (sel_sof) state_d = ST_RUN;
            ST_RUN:        if (cam_sel != active_q) state_d = ST_WAIT_FRAME;
            default:       state_d = ST_IDLE;
        endcase
        if (!enable) begin
            state_d = ST_IDLE;                  // Overrides every state.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            active_q <= CAM_1;
            seen1_q  <= 1'b0;
            seen2_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_WAIT_FRAME && state_d == ST_RUN) begin
                active_q <= cam_sel;            // Latched at the frame edge.
            end
            if (sof1) begin
                seen1_q <= 1'b1;
            end
            if (sof2) begin
                seen2_q <= 1'b1;
            end
        end
    end

    // ########################################################################
    // Outputs to the formatter
    // ########################################################################

    // While waiting, the formatter already looks at the requested camera
    // so that the sof pixel that ends the wait reaches the screen.
    assign active_cam = (state_q == ST_WAIT_FRAME) ? cam_sel : active_q;

    always_comb begin
        disp_en = 1'b0;
        if (enable) begin
            if (state_q == ST_RUN) begin
                disp_en = (cam_sel == active_q);    // Blank as soon as a switch is asked.
            end else if (state_q == ST_WAIT_FRAME) begin
                disp_en = sel_sof;
            end
        end
    end

    assign cam_inited = seen1_q & seen2_q;      // Sticky.

endmodule : aim_ctrl

`default_nettype wire

/* hdl/aim_overlay_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module aim_overlay_formatter (
    input  wire                    clk,
    input  wire                    arst_n,
    pixel_bus_if.dst               cam1,
    pixel_bus_if.dst               cam2,
    input  wire cam_pkg::cam_sel_t active_cam,
    input  wire                    disp_en,
    input  wire video_pkg::coord_t box_x,
    input  wire video_pkg::coord_t box_y,
    output logic                   hdmi_de,
    output logic                   hdmi_hsync,
    output logic                   hdmi_vsync,
    output video_pkg::chan8_t      hdmi_r,
    output video_pkg::chan8_t      hdmi_g,
    output video_pkg::chan8_t      hdmi_b
);
    import video_pkg::*;
    import cam_pkg::*;

    logic    pix_valid;
    rgb565_t pix_data;
    logic    pix_sof;
    logic    pix_sol;
    logic    show;
    coord_t  x_q;                               // Next x on the current line.
    coord_t  y_q;
    logic    tgl_q;
    coord_t  cur_x;
    coord_t  cur_y;
    logic    tgl_d;
    coord_t  dx;
    coord_t  dy;
    logic    on_box;
    rgb565_t out_pix;

    function automatic coord_t abs_diff(input coord_t a, input coord_t b);
        coord_t d;
        if (a >= b) begin
            d = a - b;
        end else begin
            d = b - a;
        end
        return d;
    endfunction

    // ########################################################################
    // Stream select and position
    // ########################################################################

    always_comb begin
        if (active_cam == CAM_1) begin
            pix_valid = cam1.valid;
            pix_data  = cam1.data;
            pix_sof   = cam1.sof;
            pix_sol   = cam1.sol;
        end else begin
            pix_valid = cam2.valid;
            pix_data  = cam2.data;
            pix_sof   = cam2.sof;
            pix_sol   = cam2.sol;
        end
    end

    always_comb begin
        cur_x = pix_sol ? '0 : x_q;
        cur_y = y_q;
        tgl_d = tgl_q;
        if (pix_sof) begin
            cur_y = '0;
            tgl_d = 1'b0;
        end else if (pix_sol) begin
            tgl_d = ~tgl_q;
            if (tgl_q) begin
                cur_y = y_q + 1'b1;             // Every second line.
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_q   <= '0;
            y_q   <= '0;
            tgl_q <= 1'b0;
        end else if (pix_valid) begin
            x_q   <= cur_x + 1'b1;
            y_q   <= cur_y;
            tgl_q <= tgl_d;
        end
    end

    // ########################################################################
    // Box outline and output stage
    // ########################################################################

    assign dx     = abs_diff(cur_x, box_x);
    assign dy     = abs_diff(cur_y, box_y);
    assign on_box = (dx <= BOX_HALF_W) && (dy <= BOX_HALF_H) &&
                    ((dx > BOX_HALF_W - BOX_LINE) || (dy > BOX_HALF_H - BOX_LINE));

    assign out_pix = on_box ? BOX_COLOR : pix_data;
    assign show    = pix_valid & disp_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdmi_de    <= 1'b0;
            hdmi_hsync <= 1'b0;
            hdmi_vsync <= 1'b0;
        end else begin
            hdmi_de    <= show;
            hdmi_hsync <= show & pix_sol;
            hdmi_vsync <= show & pix_sof;
        end
    end

    always_ff @(posedge clk) begin
        if (show) begin
            hdmi_r <= {out_pix[15:11], 3'b000};
            hdmi_g <= {out_pix[10:5], 2'b00};
            hdmi_b <= {out_pix[4:0], 3'b000};
        end else begin
            hdmi_r <= '0;
            hdmi_g <= '0;
            hdmi_b <= '0;
        end
    end

endmodule : aim_overlay_formatter

`default_nettype wire

/* hdl/aim_bot_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aim_bot_top (
    input  wire                     clk,
    input  wire                     arst_n,

    input  wire                     cam1_vsync,
    input  wire                     cam1_href,
    input  wire cam_pkg::cam_byte_t cam1_data,

    input  wire                     cam2_vsync,
    input  wire                     cam2_href,
    input  wire cam_pkg::cam_byte_t cam2_data,

    input  wire                     enable,
    input  wire cam_pkg::cam_sel_t  cam_sel,
    input  wire video_pkg::coord_t  box_x,
    input  wire video_pkg::coord_t  box_y,

    output logic                    hdmi_de,
    output logic                    hdmi_hsync,
    output logic                    hdmi_vsync,
    output video_pkg::chan8_t       hdmi_r,
    output video_pkg::chan8_t       hdmi_g,
    output video_pkg::chan8_t       hdmi_b,

    output logic                    cam_inited
);
    import cam_pkg::*;

    cam_sel_t active_cam;
    logic     disp_en;

    pixel_bus_if cam1_bus ();
    pixel_bus_if cam2_bus ();

    // ########################################################################
    // Camera byte packing
    // ########################################################################

    cam_byte_packer u_cam1_packer (
        .clk    (clk       ),
        .arst_n (arst_n    ),
        .vsync  (cam1_vsync),
        .href   (cam1_href ),
        .data   (cam1_data ),
        .pix    (cam1_bus  )
    );

    cam_byte_packer u_cam2_packer (
        .clk    (clk       ),
        .arst_n (arst_n    ),
        .vsync  (cam2_vsync),
        .href   (cam2_href ),
        .data   (cam2_data ),
        .pix    (cam2_bus  )
    );

    // ########################################################################
    // Control and display
    // ########################################################################

    aim_ctrl u_ctrl (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .enable     (enable    ),
        .cam_sel    (cam_sel   ),
        .cam1       (cam1_bus  ),
        .cam2       (cam2_bus  ),
        .active_cam (active_cam),
        .disp_en    (disp_en   ),
        .cam_inited (cam_inited)
    );

    aim_overlay_formatter u_formatter (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .cam1       (cam1_bus  ),
        .cam2       (cam2_bus  ),
        .active_cam (active_cam),
        .disp_en    (disp_en   ),
        .box_x      (box_x     ),
        .box_y      (box_y     ),
        .hdmi_de    (hdmi_de   ),
        .hdmi_hsync (hdmi_hsync),
        .hdmi_vsync (hdmi_vsync),
        .hdmi_r     (hdmi_r    ),
        .hdmi_g     (hdmi_g    ),
        .hdmi_b     (hdmi_b    )
    );

endmodule : aim_bot_top

`default_nettype wire

/* verification/aim_bot_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module aim_bot_asserts (
    input wire                    clk,
    input wire                    arst_n,
    input wire                    disp_en,
    input wire                    hdmi_de,
    input wire                    hdmi_hsync,
    input wire                    hdmi_vsync,
    input wire video_pkg::chan8_t hdmi_r,
    input wire video_pkg::chan8_t hdmi_g,
    input wire video_pkg::chan8_t hdmi_b,
    input wire                    cam_inited
);

    // Markers only ride on a data cycle.
    sync_with_de: assert property (@(posedge clk) disable iff (!arst_n)
        (hdmi_hsync || hdmi_vsync) |-> hdmi_de)
        else $error("hdmi_hsync or hdmi_vsync high without hdmi_de");

    quiet_when_off: assert property (@(posedge clk) disable iff (!arst_n)
        !disp_en |=> (!hdmi_de && !hdmi_hsync && !hdmi_vsync &&
                      hdmi_r == 8'h00 && hdmi_g == 8'h00 && hdmi_b == 8'h00))
        else $error("HDMI output active after disp_en was low");

    inited_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        cam_inited |=> cam_inited)
        else $error("cam_inited fell without a reset");

endmodule : aim_bot_asserts

bind aim_bot_top aim_bot_asserts u_asserts (
    .clk        (clk       ),
    .arst_n     (arst_n    ),
    .disp_en    (disp_en   ),
    .hdmi_de    (hdmi_de   ),
    .hdmi_hsync (hdmi_hsync),
    .hdmi_vsync (hdmi_vsync),
    .hdmi_r     (hdmi_r    ),
    .hdmi_g     (hdmi_g    ),
    .hdmi_b     (hdmi_b    ),
    .cam_inited (cam_inited)
);

`default_nettype wire

/* verification/aim_bot_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module aim_bot_tb;
    import video_pkg::*;
    import cam_pkg::*;

    localparam int NUM_ROWS    = 9;
    localparam int DRAIN_LIMIT = 200;
    localparam int M_IDLE      = 0;
    localparam int M_WAIT      = 1;
    localparam int M_RUN       = 2;

    typedef struct packed {
        logic [1:0] cams;                       // Bit 0 camera 1, bit 1 camera 2.
        logic [7:0] lines;
        logic [7:0] ppl;                        // Pixels per line.
        logic       odd;                        // Trailing odd byte per line.
        logic [7:0] chg_line;                   // Line where enable and cam_sel change.
        cam_sel_t   sel;
        logic       en;
        coord_t     bx;
        coord_t     by;
        logic       exp_inited;                 // cam_inited after the frame.
    } row_t;

    logic      clk;
    logic      arst_n;
    logic      cam1_vsync;
    logic      cam1_href;
    cam_byte_t cam1_data;
    logic      cam2_vsync;
    logic      cam2_href;
    cam_byte_t cam2_data;
    logic      enable;
    cam_sel_t  cam_sel;
    coord_t    box_x;
    coord_t    box_y;
    logic      hdmi_de;
    logic      hdmi_hsync;
    logic      hdmi_vsync;
    chan8_t    hdmi_r;
    chan8_t    hdmi_g;
    chan8_t    hdmi_b;
    logic      cam_inited;

    row_t        table_rows [NUM_ROWS];
    row_t        cur;
    logic [25:0] exp_q [$];                     // {vsync, hsync, r, g, b}.
    logic [25:0] mon_exp;
    integer      seed;
    int          m_state;
    cam_sel_t    m_sel;
    cam_sel_t    m_active;
    logic        m_en;

    aim_bot_top u_dut (
        .clk        (clk       ),
        .arst_n     (arst_n    ),
        .cam1_vsync (cam1_vsync),
        .cam1_href  (cam1_href ),
        .cam1_data  (cam1_data ),
        .cam2_vsync (cam2_vsync),
        .cam2_href  (cam2_href ),
        .cam2_data  (cam2_data ),
        .enable     (enable    ),
        .cam_sel    (cam_sel   ),
        .box_x      (box_x     ),
        .box_y      (box_y     ),
        .hdmi_de    (hdmi_de   ),
        .hdmi_hsync (hdmi_hsync),
        .hdmi_vsync (hdmi_vsync),
        .hdmi_r     (hdmi_r    ),
        .hdmi_g     (hdmi_g    ),
        .hdmi_b     (hdmi_b    ),
        .cam_inited (cam_inited)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ########################################################################
    // Reporting
    // ########################################################################

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected pixels never reached the output", exp_q.size());
            stop_run();
        end
    endtask

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic logic cam_on(input cam_sel_t c);
        return (c == CAM_1) ? cur.cams[0] : cur.cams[1];
    endfunction

    function automatic logic [23:0] expected_rgb(input logic [15:0] pix, input int x,
                                                 input int y);
        int          dx;
        int          dy;
        logic [15:0] p;
        dx = (x > int'(cur.bx)) ? x - int'(cur.bx) : int'(cur.bx) - x;
        dy = (y > int'(cur.by)) ? y - int'(cur.by) : int'(cur.by) - y;
        p  = pix;
        // Inside the box and no further than BOX_LINE-1 from an edge.
        if (dx <= int'(BOX_HALF_W) && dy <= int'(BOX_HALF_H) &&
            (dx >= int'(BOX_HALF_W) - int'(BOX_LINE) + 1 ||
             dy >= int'(BOX_HALF_H) - int'(BOX_LINE) + 1)) begin
            p = BOX_COLOR;
        end
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    task automatic model_gap();
        if (!m_en) begin
            m_state = M_IDLE;
        end else if (m_state == M_IDLE) begin
            m_state = M_WAIT;
        end else if (m_state == M_RUN && m_sel != m_active) begin
            m_state = M_WAIT;
        end
    endtask

    task automatic model_pixel(input int l, input int p, input logic [31:0] bytes);
        logic        sof;
        logic [15:0] pix;
        sof = (l == 0) && (p == 0);
        if (m_state == M_WAIT && sof && cam_on(m_sel)) begin
            m_state  = M_RUN;                   // Frame edge latches the camera.
            m_active = m_sel;
        end
        if (m_state == M_RUN && cam_on(m_active)) begin
            pix = (m_active == CAM_1) ? bytes[15:0] : bytes[31:16];
            exp_q.push_back({sof, p == 0, expected_rgb(pix, p, l >> 1)});
        end
    endtask

    // ########################################################################
    // Stimulus
    // ########################################################################

    task automatic drive_cycle(input logic vs, input logic hr, input logic [7:0] d1,
                               input logic [7:0] d2);
        @(posedge clk);
        cam1_vsync <= vs & cur.cams[0];
        cam1_href  <= hr & cur.cams[0];
        cam1_data  <= d1;
        cam2_vsync <= vs & cur.cams[1];
        cam2_href  <= hr & cur.cams[1];
        cam2_data  <= d2;
    endtask

    task automatic apply_controls();
        @(posedge clk);
        enable  <= cur.en;
        cam_sel <= cur.sel;
        m_en  = cur.en;
        m_sel = cur.sel;
    endtask

    task automatic play_frame();
        int          l;
        int          p;
        logic [31:0] bytes;
        @(posedge clk);
        box_x <= cur.bx;
        box_y <= cur.by;
        if (cur.chg_line == 8'd0) begin
            apply_controls();
        end
        model_gap();
        repeat (3) drive_cycle(1'b1, 1'b0, 8'h00, 8'h00);   // Vsync pulse.
        repeat (3) drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
        for (l = 0; l < int'(cur.lines); l++) begin
            repeat (4) drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
            // Line blanking, the previous line has left the pipeline.
            if (l == int'(cur.chg_line) && l != 0) begin
                apply_controls();
                model_gap();
            end
            for (p = 0; p < int'(cur.ppl); p++) begin
                bytes = $random(seed);
                model_pixel(l, p, bytes);
                drive_cycle(1'b0, 1'b1, bytes[15:8], bytes[31:24]);
                drive_cycle(1'b0, 1'b1, bytes[7:0], bytes[23:16]);
            end
            if (cur.odd) begin
                bytes = $random(seed);
                drive_cycle(1'b0, 1'b1, bytes[7:0], bytes[15:8]);
            end
        end
        repeat (6) drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
    endtask

    task automatic fill_table();
        // cams lines ppl odd chg sel en box_x box_y cam_inited
        table_rows[0] = '{2'b01, 8'd4, 8'd16, 1'b0, 8'd0, CAM_1, 1'b0, 11'd20, 11'd13, 1'b0};
        table_rows[1] = '{2'b11, 8'd4, 8'd16, 1'b0, 8'd0, CAM_1, 1'b0, 11'd20, 11'd13, 1'b1};
        table_rows[2] = '{2'b11, 8'd8, 8'd40, 1'b0, 8'd0, CAM_1, 1'b1, 11'd20, 11'd13, 1'b1};
        table_rows[3] = '{2'b11, 8'd8, 8'd40, 1'b0, 8'd0, CAM_1, 1'b1, 11'd20, 11'd2, 1'b1};
        table_rows[4] = '{2'b11, 8'd8, 8'd40, 1'b0, 8'd3, CAM_2, 1'b1, 11'd20, 11'd13, 1'b1};
        table_rows[5] = '{2'b11, 8'd8, 8'd40, 1'b0, 8'd0, CAM_2, 1'b1, 11'd24, 11'd13, 1'b1};
        table_rows[6] = '{2'b11, 8'd6, 8'd32, 1'b1, 8'd0, CAM_2, 1'b1, 11'd10, 11'd1, 1'b1};
        table_rows[7] = '{2'b11, 8'd8, 8'd40, 1'b0, 8'd4, CAM_2, 1'b0, 11'd20, 11'd13, 1'b1};
        table_rows[8] = '{2'b11, 8'd4, 8'd24, 1'b0, 8'd0, CAM_1, 1'b1, 11'd12, 11'd2, 1'b1};
    endtask

    // Every output pixel is compared in order.
    always @(negedge clk) begin
        if (arst_n === 1'b1 && hdmi_de === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected pixel: hdmi_de was high with no pixel expected");
                stop_run();
            end else begin
                mon_exp = exp_q.pop_front();
                check_value("hdmi_vsync", hdmi_vsync, mon_exp[25]);
                check_value("hdmi_hsync", hdmi_hsync, mon_exp[24]);
                check_value("hdmi_r", hdmi_r, mon_exp[23:16]);
                check_value("hdmi_g", hdmi_g, mon_exp[15:8]);
                check_value("hdmi_b", hdmi_b, mon_exp[7:0]);
            end
        end
    end

    initial begin
        int r;
        seed       = 7469;
        arst_n     = 1'b0;
        cam1_vsync = 1'b0;
        cam1_href  = 1'b0;
        cam1_data  = '0;
        cam2_vsync = 1'b0;
        cam2_href  = 1'b0;
        cam2_data  = '0;
        enable     = 1'b0;
        cam_sel    = CAM_1;
        box_x      = '0;
        box_y      = '0;
        m_state    = M_IDLE;
        m_sel      = CAM_1;
        m_active   = CAM_1;
        m_en       = 1'b0;
        fill_table();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("cam_inited", cam_inited, 32'd0);
        for (r = 0; r < NUM_ROWS; r++) begin
            cur = table_rows[r];
            play_frame();
            wait_drain();
            @(negedge clk);
            check_value("cam_inited", cam_inited, cur.exp_inited);
        end
        $display("Test OK");
        $finish;
    end

endmodule : aim_bot_tb

`default_nettype wire

/* verilog.f */
hdl/video_pkg.sv
hdl/cam_pkg.sv
hdl/pixel_bus_if.sv
hdl/cam_byte_packer.sv
hdl/aim_ctrl.sv
hdl/aim_overlay_formatter.sv
hdl/aim_bot_top.sv
verification/aim_bot_asserts.sv
verification/aim_bot_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the aim_bot testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module aim_bot_tb \
    -o aim_bot_sim

# The simulator exits non-zero on $fatal, so the log decides the result.
./obj_dir/aim_bot_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
